// File: all.f
src/rmw_pkg.sv
src/inst_queue.sv
src/reg_file.sv
src/pipe_control.sv
src/operand_bypass.sv
src/execute_unit.sv
src/rmw_top.sv
verification/rmw_checker.sv
verification/rmw_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator.
# Exits non-zero when the simulation log reports a failure.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --top-module rmw_tb -f all.f -o rmw_sim

./obj_dir/rmw_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"

// File: verification/rmw_tb.sv
/*
  Testbench top for the read-modify-write pipeline.
  Drives random instructions and hold bursts from an LFSR, then fills
  the queue under hold, and waits for every result before the verdict.
  The comparing is done by the checker instance beside the DUT.
*/
module rmw_tb
  import rmw_pkg::*;
#(
  parameter int QUEUE_DEPTH = 16
);

  localparam int NUM_INST     = 400;
  localparam int RANDOM_LIMIT = 20000;
  localparam int DRAIN_LIMIT  = 2000;

  logic        clk;
  logic        rst;
  logic        hold;
  logic        in_pass;
  reg_t        in_ra0;
  reg_t        in_ra1;
  reg_t        in_wa;
  opcode_t     in_op;
  imm_t        in_imm;
  logic        in_accept;
  logic        out_vld_r;
  reg_t        out_wa_r;
  word_t       out_wdata_r;
  logic        fill_check;
  int          value_errors;
  int          other_errors;
  int          accepted;
  int          results;
  int          timeouts;
  logic [31:0] lfsr_state;
  reg_t        last_wa;

  // 8 unit period
  always #4 clk = ~clk;

  rmw_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dut_i (
    .clk         (clk),
    .rst         (rst),
    .hold        (hold),
    .in_pass     (in_pass),
    .in_ra0      (in_ra0),
    .in_ra1      (in_ra1),
    .in_wa       (in_wa),
    .in_op       (in_op),
    .in_imm      (in_imm),
    .in_accept   (in_accept),
    .out_vld_r   (out_vld_r),
    .out_wa_r    (out_wa_r),
    .out_wdata_r (out_wdata_r)
  );

  rmw_checker #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) check_i (
    .clk          (clk),
    .rst          (rst),
    .hold         (hold),
    .in_pass      (in_pass),
    .in_ra0       (in_ra0),
    .in_ra1       (in_ra1),
    .in_wa        (in_wa),
    .in_op        (in_op),
    .in_imm       (in_imm),
    .in_accept    (in_accept),
    .out_vld_r    (out_vld_r),
    .out_wa_r     (out_wa_r),
    .out_wdata_r  (out_wdata_r),
    .fill_check   (fill_check),
    .value_errors (value_errors),
    .other_errors (other_errors),
    .accepted     (accepted),
    .results      (results)
  );

  // 32-bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // n fresh bits, one lfsr step per bit
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // random instruction fields on the input ports
  task automatic drive_random_inst();
    logic [31:0] bits;
    draw_bits(3, bits);
    in_ra0 = bits[2:0];
    draw_bits(1, bits);
    // half the time chain on the previous destination
    if (bits[0])
      in_ra0 = last_wa;
    draw_bits(3, bits);
    in_ra1 = bits[2:0];
    draw_bits(3, bits);
    in_wa = bits[2:0];
    // codes 9 to 15 hit the pass-through default
    draw_bits(4, bits);
    in_op = opcode_t'(bits[3:0]);
    draw_bits(16, bits);
    in_imm = bits[15:0];
    last_wa = in_wa;
  endtask

  // random traffic with hold bursts until NUM_INST are taken
  task automatic run_random();
    logic [31:0] bits;
    int          sent;
    int          cycles;
    int          hold_left;
    sent = 0;
    cycles = 0;
    hold_left = 0;
    while ((sent < NUM_INST) && (cycles < RANDOM_LIMIT))
    begin
      @(posedge clk);
      #1;
      drive_random_inst();
      draw_bits(1, bits);
      in_pass = bits[0];
      if (hold_left > 0)
      begin
        hold = 1'b1;
        hold_left--;
      end
      else
      begin
        hold = 1'b0;
        // roughly one burst start in 16 cycles, 1 to 8 long
        draw_bits(4, bits);
        if (bits[3:0] == 4'd0)
        begin
          draw_bits(3, bits);
          hold_left = 1 + int'(bits[2:0]);
        end
      end
      // taken on the coming edge
      @(negedge clk);
      if (in_pass && in_accept)
        sent++;
      cycles++;
    end
    @(posedge clk);
    #1;
    in_pass = 1'b0;
    hold = 1'b0;
    if (sent < NUM_INST)
    begin
      $display("timeout: only %0d of %0d instructions taken in %0d cycles",
               sent, NUM_INST, RANDOM_LIMIT);
      timeouts++;
    end
  endtask

  // wait until every taken instruction has come out
  task automatic wait_drained();
    int n;
    n = 0;
    while ((results != accepted) && (n < DRAIN_LIMIT))
    begin
      @(posedge clk);
      n++;
    end
    if (results != accepted)
    begin
      $display("timeout: %0d of %0d results seen after %0d cycles",
               results, accepted, DRAIN_LIMIT);
      timeouts++;
    end
  endtask

  // push under hold until the queue refuses, then release
  task automatic fill_queue();
    int   n;
    logic full;
    n = 0;
    full = 1'b0;
    @(posedge clk);
    #1;
    hold = 1'b1;
    in_pass = 1'b0;
    @(posedge clk);
    #1;
    fill_check = 1'b1;
    while (!full && (n < 4 * QUEUE_DEPTH))
    begin
      drive_random_inst();
      in_pass = 1'b1;
      @(negedge clk);
      full = ~in_accept;
      @(posedge clk);
      #1;
      n++;
    end
    in_pass = 1'b0;
    if (!full)
    begin
      $display("timeout: in_accept never fell with hold high");
      timeouts++;
    end
    // stay frozen a while, no pulse may appear
    repeat (6) @(posedge clk);
    #1;
    fill_check = 1'b0;
    hold = 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    rst = 1'b1;
    hold = 1'b0;
    in_pass = 1'b0;
    in_ra0 = '0;
    in_ra1 = '0;
    in_wa = '0;
    in_op = OP_AND;
    in_imm = '0;
    fill_check = 1'b0;
    timeouts = 0;
    last_wa = '0;
    lfsr_state = 32'd95850;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    run_random();
    if (timeouts == 0)
      wait_drained();
    if (timeouts == 0)
      fill_queue();
    if (timeouts == 0)
      wait_drained();
    $display("done: %0d results, %0d value errors, %0d other errors, %0d timeouts",
             results, value_errors, other_errors, timeouts);
    if ((value_errors + other_errors + timeouts) == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: verification/rmw_checker.sv
/*
  Scoreboard beside the pipeline DUT.
  Samples the ports on the falling edge, queues every accepted
  instruction, runs a model register file in acceptance order and
  compares each output pulse. Counts go back to the testbench top.
*/
module rmw_checker
  import rmw_pkg::*;
#(
  parameter int QUEUE_DEPTH = 16
)
(
  input  logic    clk,
  input  logic    rst,
  input  logic    hold,
  input  logic    in_pass,
  input  reg_t    in_ra0,
  input  reg_t    in_ra1,
  input  reg_t    in_wa,
  input  opcode_t in_op,
  input  imm_t    in_imm,
  input  logic    in_accept,
  input  logic    out_vld_r,
  input  reg_t    out_wa_r,
  input  word_t   out_wdata_r,
  input  logic    fill_check,
  output int      value_errors,
  output int      other_errors,
  output int      accepted,
  output int      results
);

  inst_t pending [$];
  word_t model_regs [NUM_REGS];
  inst_t taken;
  logic  hold_prev;
  logic  reset_checked;
  logic  fill_done;
  int    fill_count;

  // expected result from the operation rules
  function automatic word_t model_op(input inst_t inst, input word_t a, input word_t b);
    case (inst.op)
      OP_AND:  return a & b;
      OP_NOT:  return ~a;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ADD:  return a + b;
      // two's complement subtract
      OP_SUB:  return a + ~b + 32'd1;
      OP_MOV0: return a;
      OP_MOV1: return b;
      OP_MOVI: return {16'h0000, inst.imm};
      default: return a;
    endcase
  endfunction

  // oldest pending instruction against the output registers
  task automatic check_result();
    inst_t exp_inst;
    word_t exp_data;
    if (pending.size() == 0)
    begin
      $display("output pulse at time %0t with no instruction outstanding", $time);
      other_errors++;
    end
    else
    begin
      exp_inst = pending.pop_front();
      exp_data = model_op(exp_inst, model_regs[exp_inst.ra0], model_regs[exp_inst.ra1]);
      model_regs[exp_inst.wa] = exp_data;
      results++;
      if (out_wa_r !== exp_inst.wa)
      begin
        $display("FAIL time %0t out_wa_r got %0d expected %0d", $time, out_wa_r, exp_inst.wa);
        value_errors++;
      end
      if (out_wdata_r !== exp_data)
      begin
        $display("FAIL time %0t out_wdata_r got %h expected %h", $time, out_wdata_r, exp_data);
        value_errors++;
      end
    end
  endtask

  // sample on the falling edge once all ports have settled
  always @(negedge clk)
  begin
    if (rst)
    begin
      pending.delete();
      for (int i = 0; i < NUM_REGS; i++)
        model_regs[i] = '0;
      value_errors = 0;
      other_errors = 0;
      accepted = 0;
      results = 0;
      hold_prev = 1'b0;
      reset_checked = 1'b0;
      fill_done = 1'b0;
      fill_count = 0;
    end
    else
    begin
      // first cycle out of reset
      if (!reset_checked)
      begin
        if (in_accept !== 1'b1)
        begin
          $display("FAIL time %0t in_accept got %b expected 1", $time, in_accept);
          value_errors++;
        end
        if (out_vld_r !== 1'b0)
        begin
          $display("FAIL time %0t out_vld_r got %b expected 0", $time, out_vld_r);
          value_errors++;
        end
        reset_checked = 1'b1;
      end
      // hold at the last edge means no strobe now
      if (out_vld_r && hold_prev)
      begin
        $display("output pulse at time %0t right after a held edge", $time);
        other_errors++;
      end
      if (out_vld_r)
        check_result();
      // instruction taken on the coming edge
      if (in_pass && in_accept)
      begin
        taken.ra0 = in_ra0;
        taken.ra1 = in_ra1;
        taken.wa  = in_wa;
        taken.op  = in_op;
        taken.imm = in_imm;
        pending.push_back(taken);
        accepted++;
        if (fill_check)
          fill_count++;
      end
      // queue filled from empty under hold
      if (fill_check && !in_accept && !fill_done)
      begin
        if (fill_count != QUEUE_DEPTH)
        begin
          $display("queue took %0d instructions before in_accept fell, expected %0d",
                   fill_count, QUEUE_DEPTH);
          other_errors++;
        end
        fill_done = 1'b1;
      end
      hold_prev = hold;
    end
  end

endmodule

// File: src/rmw_top.sv
/*
  Top level of the read-modify-write pipeline.
  Instructions enter through the queue when in_accept is high and
  leave as a one-cycle out_vld_r pulse with destination and result.
  hold freezes the pipeline while the queue keeps accepting.
*/
module rmw_top
  import rmw_pkg::*;
#(
  parameter int QUEUE_DEPTH = 16
)
(
  input  logic    clk,
  input  logic    rst,
  input  logic    hold,
  input  logic    in_pass,
  input  reg_t    in_ra0,
  input  reg_t    in_ra1,
  input  reg_t    in_wa,
  input  opcode_t in_op,
  input  imm_t    in_imm,
  output logic    in_accept,
  output logic    out_vld_r,
  output reg_t    out_wa_r,
  output word_t   out_wdata_r
);

  inst_t in_inst;
  inst_t head_inst;
  inst_t s2_inst;
  logic  queue_empty;
  logic  s1_adv;
  logic  s2_adv;
  logic  s3_adv;
  logic  s4_adv;
  logic  s3_vld_r;
  word_t rdata0;
  word_t rdata1;
  word_t operand0;
  word_t operand1;
  reg_t  s3_wa;
  word_t s3_wdata;

  // pack the loose input fields
  assign in_inst = '{ra0: in_ra0, ra1: in_ra1, wa: in_wa, op: in_op, imm: in_imm};

  inst_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) queue_i (
    .clk       (clk),
    .rst       (rst),
    .in_pass   (in_pass),
    .in_inst   (in_inst),
    .in_accept (in_accept),
    .pop       (s1_adv),
    .empty_r   (queue_empty),
    .head_inst (head_inst)
  );

  pipe_control control_i (
    .clk         (clk),
    .rst         (rst),
    .hold        (hold),
    .queue_empty (queue_empty),
    .s1_adv      (s1_adv),
    .s2_adv      (s2_adv),
    .s3_adv      (s3_adv),
    .s4_adv      (s4_adv),
    .s3_vld_r    (s3_vld_r)
  );

  // read issued as the S1 instruction moves on, data lands in S2
  // writeback of S3 on the S4 advance
  reg_file rf_i (
    .clk    (clk),
    .rst    (rst),
    .ren    (s2_adv),
    .ra0    (head_inst.ra0),
    .ra1    (head_inst.ra1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .wen    (s4_adv),
    .wa     (s3_wa),
    .wdata  (s3_wdata)
  );

  operand_bypass bypass_ra0_i (
    .src_reg  (s2_inst.ra0),
    .rf_data  (rdata0),
    .fwd_vld  (s3_vld_r),
    .fwd_reg  (s3_wa),
    .fwd_data (s3_wdata),
    .operand  (operand0)
  );

  operand_bypass bypass_ra1_i (
    .src_reg  (s2_inst.ra1),
    .rf_data  (rdata1),
    .fwd_vld  (s3_vld_r),
    .fwd_reg  (s3_wa),
    .fwd_data (s3_wdata),
    .operand  (operand1)
  );

  execute_unit execute_i (
    .clk         (clk),
    .rst         (rst),
    .s2_adv      (s2_adv),
    .s3_adv      (s3_adv),
    .s4_adv      (s4_adv),
    .head_inst   (head_inst),
    .operand0    (operand0),
    .operand1    (operand1),
    .s2_inst     (s2_inst),
    .s3_wa       (s3_wa),
    .s3_wdata    (s3_wdata),
    .out_vld_r   (out_vld_r),
    .out_wa_r    (out_wa_r),
    .out_wdata_r (out_wdata_r)
  );

endmodule

// File: src/execute_unit.sv
/*
  Datapath stages of the pipeline.
  Holds the S2 instruction, computes the result into S3 from the
  two bypassed operands, and drives the writeback and the output
  registers on the S4 advance.
*/
module execute_unit
  import rmw_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  s2_adv,
  input  logic  s3_adv,
  input  logic  s4_adv,
  input  inst_t head_inst,
  input  word_t operand0,
  input  word_t operand1,
  output inst_t s2_inst,
  output reg_t  s3_wa,
  output word_t s3_wdata,
  output logic  out_vld_r,
  output reg_t  out_wa_r,
  output word_t out_wdata_r
);

  word_t s2_result;

  // operation set
  function automatic word_t exe(opcode_t op, imm_t imm, word_t a, word_t b);
    word_t r;
    case (op)
      OP_AND:  r = a & b;
      OP_NOT:  r = ~a;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_MOV0: r = a;
      OP_MOV1: r = b;
      // zero-extend the immediate
      OP_MOVI: r = {{($bits(word_t) - $bits(imm_t)){1'b0}}, imm};
      default: r = a;
    endcase
    return r;
  endfunction

  // S2 instruction, taken from the S1 head register
  always_ff @(posedge clk)
  begin
    if (s2_adv)
      s2_inst <= head_inst;
  end

  assign s2_result = exe(s2_inst.op, s2_inst.imm, operand0, operand1);

  // S3 result and destination
  // these also feed writeback and the forwarding path
  always_ff @(posedge clk)
  begin
    if (s3_adv)
    begin
      s3_wa    <= s2_inst.wa;
      s3_wdata <= s2_result;
    end
  end

  // output strobe, one pulse per result
  always_ff @(posedge clk)
  begin
    if (rst)
      out_vld_r <= 1'b0;
    else
      out_vld_r <= s4_adv;
  end

  // output payload, loaded with the writeback
  always_ff @(posedge clk)
  begin
    if (s4_adv)
    begin
      out_wa_r    <= s3_wa;
      out_wdata_r <= s3_wdata;
    end
  end

endmodule

// File: src/operand_bypass.sv
/*
  Forwarding selector for one source operand in S2.
  Picks the S3 result when it is valid and targets this source
  register, otherwise the register file read data.
  One instance per source operand.
*/
module operand_bypass
  import rmw_pkg::*;
(
  input  reg_t  src_reg,
  input  word_t rf_data,
  input  logic  fwd_vld,
  input  reg_t  fwd_reg,
  input  word_t fwd_data,
  output word_t operand
);

  logic hit;

  // newer in-flight result for the same register
  assign hit = fwd_vld & (fwd_reg == src_reg);

  // older results are already in the file
  // or caught by the write-first read
  assign operand = hit ? fwd_data : rf_data;

endmodule

// File: src/pipe_control.sv
/*
  Pipeline control for the four stages.
  Tracks the valid bits of S1 to S3 and derives one advance enable
  per stage. The hold input freezes every stage at once.
  s1_adv doubles as the queue pop, s4_adv as writeback and output load.
*/
module pipe_control
(
  input  logic clk,
  input  logic rst,
  input  logic hold,
  input  logic queue_empty,
  output logic s1_adv,
  output logic s2_adv,
  output logic s3_adv,
  output logic s4_adv,
  output logic s3_vld_r
);

  logic s1_vld_r;
  logic s2_vld_r;

  // a stage loads when the one before it has an item
  // and the pipe is not held
  assign s1_adv = ~queue_empty & ~hold;
  assign s2_adv = s1_vld_r & ~hold;
  assign s3_adv = s2_vld_r & ~hold;
  assign s4_adv = s3_vld_r & ~hold;

  // valid bits move in lockstep
  // an empty stage upstream leaves a bubble
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      s1_vld_r <= 1'b0;
      s2_vld_r <= 1'b0;
      s3_vld_r <= 1'b0;
    end
    else if (!hold)
    begin
      s1_vld_r <= s1_adv;
      s2_vld_r <= s2_adv;
      s3_vld_r <= s3_adv;
    end
  end

endmodule

// File: src/reg_file.sv
/*
  Register file with two registered read ports and one write port.
  A read of the register being written in the same cycle returns
  the new data. All registers clear to zero on reset.
*/
module reg_file
  import rmw_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  ren,
  input  reg_t  ra0,
  input  reg_t  ra1,
  output word_t rdata0,
  output word_t rdata1,
  input  logic  wen,
  input  reg_t  wa,
  input  word_t wdata
);

  word_t regs_r [NUM_REGS];

  // write port
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs_r[i] <= '0;
    end
    else if (wen)
      regs_r[wa] <= wdata;
  end

  // read ports, data held until the next read
  // write-first so a same-cycle writeback is seen
  always_ff @(posedge clk)
  begin
    if (ren)
    begin
      rdata0 <= (wen && wa == ra0) ? wdata : regs_r[ra0];
      rdata1 <= (wen && wa == ra1) ? wdata : regs_r[ra1];
    end
  end

endmodule

// File: src/inst_queue.sv
/*
  Circular instruction FIFO in front of the pipeline.
  Accepts an instruction whenever it is not full and pops on the
  S1 advance, loading the entry at the read pointer into the S1
  head register. Full and empty are registered.
*/
module inst_queue
  import rmw_pkg::*;
#(
  parameter int QUEUE_DEPTH = 16
)
(
  input  logic  clk,
  input  logic  rst,
  input  logic  in_pass,
  input  inst_t in_inst,
  output logic  in_accept,
  input  logic  pop,
  output logic  empty_r,
  output inst_t head_inst
);

  // extra top bit on each pointer tells full from empty
  localparam int ADDR_W = $clog2(QUEUE_DEPTH);
  localparam int PTR_W  = ADDR_W + 1;

  inst_t            mem_r [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W-1:0] wr_ptr_nxt;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic             full_r;
  logic             push;

  // accept level does not depend on hold
  assign in_accept = ~full_r;
  assign push      = in_pass & in_accept;

  assign wr_ptr_nxt = wr_ptr_r + {{ADDR_W{1'b0}}, push};
  assign rd_ptr_nxt = rd_ptr_r + {{ADDR_W{1'b0}}, pop};

  // pointers and flags, flags follow the next pointers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      empty_r  <= 1'b1;
      full_r   <= 1'b0;
    end
    else
    begin
      wr_ptr_r <= wr_ptr_nxt;
      rd_ptr_r <= rd_ptr_nxt;
      empty_r  <= (wr_ptr_nxt == rd_ptr_nxt);
      // same slot, opposite lap
      full_r   <= (wr_ptr_nxt[ADDR_W] != rd_ptr_nxt[ADDR_W]) &&
                  (wr_ptr_nxt[ADDR_W-1:0] == rd_ptr_nxt[ADDR_W-1:0]);
    end
  end

  // storage
  always_ff @(posedge clk)
  begin
    if (push)
      mem_r[wr_ptr_r[ADDR_W-1:0]] <= in_inst;
  end

  // S1 register, takes the entry at the read pointer as it pops
  always_ff @(posedge clk)
  begin
    if (pop)
      head_inst <= mem_r[rd_ptr_r[ADDR_W-1:0]];
  end

endmodule

// File: src/rmw_pkg.sv
/*
  Shared types for the read-modify-write pipeline.
  Defines the data word, register index, immediate, opcode encoding
  and the packed instruction word that travels through the queue.
  Imported by every RTL module that carries one of these types.
*/
package rmw_pkg;

  // data word carried by registers, operands and results
  typedef logic [31:0] word_t;

  // register index, 8 architectural registers
  typedef logic [2:0] reg_t;

  // immediate, zero-extended by MOVI
  typedef logic [15:0] imm_t;

  // register count follows the index width
  localparam int NUM_REGS = 2 ** $bits(reg_t);

  // operation encoding
  // codes above OP_MOVI pass source 0 through
  typedef enum logic [3:0] {
    OP_AND  = 4'd0,
    OP_NOT  = 4'd1,
    OP_OR   = 4'd2,
    OP_XOR  = 4'd3,
    OP_ADD  = 4'd4,
    OP_SUB  = 4'd5,
    OP_MOV0 = 4'd6,
    OP_MOV1 = 4'd7,
    OP_MOVI = 4'd8
  } opcode_t;

  // instruction word, 29 bits
  typedef struct packed {
    reg_t    ra0;
    reg_t    ra1;
    reg_t    wa;
    opcode_t op;
    imm_t    imm;
  } inst_t;

endpackage
